// ==== duckAnim.f ====
src/animPkg.sv
src/pathRomBus.sv
src/pathRomArbiter.sv
src/dogControl.sv
src/duckControl.sv
src/spriteCmdOut.sv
src/duckAnimTop.sv
sim/duckAnim_assert.sv
sim/duckAnimTb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the duck animation testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module duckAnimTb \
    -f duckAnim.f -o duckAnimSim \
    && ./obj_dir/duckAnimSim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "test passed" sim.log && ! grep -q "test failed" sim.log \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

// ==== sim/duckAnim_testdata.txt ====
# Header: run duckColor duckDirection duckStartX creditHoldMask(hex)
# Then one expected command per line: sprite(0 dog, 1 duck) frame x y
1 1 2 200 00F0
0 0 11 290
0 1 19 290
0 2 27 290
0 3 35 290
0 3 43 290
0 1 51 290
0 2 59 290
0 3 67 290
0 3 75 290
0 4 75 290
0 5 75 290
0 1 83 290
0 2 91 290
0 3 99 290
0 3 107 290
0 1 115 290
0 2 123 290
0 3 131 290
0 3 139 290
0 4 139 290
0 5 139 290
0 6 139 290
0 7 139 290
0 7 148 274
0 7 157 260
0 7 166 248
0 7 175 238
0 7 184 229
0 7 193 222
0 7 202 217
0 7 213 213
0 7 224 212
0 8 224 212
0 8 235 213
0 8 246 217
0 8 255 222
0 8 264 229
0 8 273 238
0 8 282 248
0 8 291 260
0 8 300 274
0 8 309 290
1 12 200 300
1 12 204 296
1 13 208 292
1 13 212 288
1 12 216 284
1 12 220 280
1 13 224 276
1 13 228 272
1 12 232 268
1 12 236 264
1 13 240 260
1 13 244 256
1 12 248 252

// ==== sim/duckAnimTb.sv ====
`timescale 1ns/100ps

module duckAnimTb import animPkg::*; ();

    localparam int WALK_SEGMENTS = 2;
    localparam int WAIT_FRAMES   = 10;
    localparam int FLIGHT_STEPS  = 12;
    localparam int CMD_CREDITS   = 4;
    localparam int MARGIN_CYCLES = 3000;
    localparam int STALL_CYCLES  = 100;       // Credit held back for masked commands
    localparam logic [15:0] LFSR_TAPS = 16'hB400;
    localparam logic [9:0] BOB_OFFSET [4] = '{10'd0, 10'd2, 10'd4, 10'd2};   // Hold bob per frame

    logic       ANIM_Clk;
    logic       Reset;
    logic       frameTick;
    logic       run;
    logic [1:0] duckColor;
    logic [1:0] duckDirection;
    logic [9:0] duckStartX;
    logic       cmdCredit;
    logic       cmdValid;
    logic       cmdSprite;
    logic [4:0] cmdFrame;
    logic [9:0] cmdX;
    logic [9:0] cmdY;

    spriteCmd_t  dogQ[$];
    spriteCmd_t  duckQ[$];
    int          dueQ[$];        // Cycle at which each credit goes back
    logic [15:0] lfsr;
    logic [15:0] holdMask;
    logic [9:0]  lastDogX;
    logic        runValue;
    int          cycle;
    int          sentCount;
    int          holdCount;
    int          errors;
    int          flowErrors;
    int          expectTotal;

    duckAnimTop #(
        .WALK_SEGMENTS (WALK_SEGMENTS),
        .WAIT_FRAMES   (WAIT_FRAMES),
        .FLIGHT_STEPS  (FLIGHT_STEPS),
        .CMD_CREDITS   (CMD_CREDITS)
    ) DUT (
        .ANIM_Clk      (ANIM_Clk),
        .Reset         (Reset),
        .frameTick     (frameTick),
        .run           (run),
        .duckColor     (duckColor),
        .duckDirection (duckDirection),
        .duckStartX    (duckStartX),
        .cmdCredit     (cmdCredit),
        .cmdValid      (cmdValid),
        .cmdSprite     (cmdSprite),
        .cmdFrame      (cmdFrame),
        .cmdX          (cmdX),
        .cmdY          (cmdY)
    );

    initial ANIM_Clk = 1'b0;
    always #5 ANIM_Clk = ~ANIM_Clk;

    // Galois LFSR, one step per bit
    task automatic drawBits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++)
        begin
            val  = (val << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
    endtask

    task automatic loadTestData();
        int    fd;
        int    n;
        int    s;
        int    f;
        int    x;
        int    y;
        int    c;
        bit    gotHeader;
        string line;
        spriteCmd_t cmd;
        gotHeader = 0;
        fd = $fopen("sim/duckAnim_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open sim/duckAnim_testdata.txt");
            return;
        end
        while ($fgets(line, fd) > 0)
        begin
            if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == 8'h0A)
                continue;
            if (!gotHeader)
            begin
                n = $sscanf(line, "%d %d %d %d %h", s, f, x, y, c);
                runValue      = s[0];
                duckColor     = 2'(f);
                duckDirection = 2'(x);
                duckStartX    = 10'(y);
                holdMask      = 16'(c);
                gotHeader     = (n == 5);
            end
            else if ($sscanf(line, "%d %d %d %d", s, f, x, y) == 4)
            begin
                cmd.sprite = sprite_e'(s[0]);
                cmd.frame  = 5'(f);
                cmd.x      = 10'(x);
                cmd.y      = 10'(y);
                if (s == 0)
                    dogQ.push_back(cmd);
                else
                    duckQ.push_back(cmd);
            end
        end
        $fclose(fd);
        expectTotal = dogQ.size() + duckQ.size();
    endtask

    task automatic checkCommand();
        spriteCmd_t exp;
        if (cmdSprite == SprDog && dogQ.size() == 0 && cmdFrame == 5'd9)
        begin
            // Hold frames repeat until the duck is gone
            if (cmdX != lastDogX || cmdY != DOG_GROUND_Y - BOB_OFFSET[holdCount % 4])
            begin
                errors++;
                $display("FAILED at %0t: hold frame %0d got x=%0d y=%0d", $time,
                         holdCount, cmdX, cmdY);
            end
            holdCount++;
        end
        else if ((cmdSprite == SprDog && dogQ.size() == 0)
                 || (cmdSprite == SprDuck && duckQ.size() == 0))
        begin
            errors++;
            $display("Extra %s command after the expected stream at %0t",
                     cmdSprite ? "duck" : "dog", $time);
        end
        else
        begin
            exp = (cmdSprite == SprDog) ? dogQ.pop_front() : duckQ.pop_front();
            if (cmdFrame != exp.frame || cmdX != exp.x || cmdY != exp.y)
            begin
                errors++;
                $display("FAILED at %0t: %s expected f=%0d x=%0d y=%0d got f=%0d x=%0d y=%0d",
                         $time, cmdSprite ? "duck" : "dog", exp.frame, exp.x, exp.y,
                         cmdFrame, cmdX, cmdY);
            end
            if (cmdSprite == SprDog)
                lastDogX = exp.x;
        end
    endtask

    // Ticks, output checks and credit return, all 1 ns after the edge
    always @(posedge ANIM_Clk)
    begin
        int delay;
        int idx;
        #1;
        cycle++;
        frameTick = (cycle % 4 == 0);
        if (cmdValid)
        begin
            drawBits(4, delay);
            if (holdMask[sentCount % 16])
                delay += STALL_CYCLES;
            sentCount++;
            dueQ.push_back(cycle + delay + 2);
            checkCommand();
        end
        cmdCredit = 1'b0;
        idx = -1;
        foreach (dueQ[i])
            if (idx < 0 && dueQ[i] <= cycle)
                idx = i;
        if (idx >= 0)
        begin
            cmdCredit = 1'b1;
            dueQ.delete(idx);
        end
    end

    initial
    begin
        Reset         = 1'b1;
        frameTick     = 1'b0;
        run           = 1'b0;
        duckColor     = 2'd0;
        duckDirection = 2'd0;
        duckStartX    = 10'd0;
        cmdCredit     = 1'b0;
        lfsr          = 16'd38;
        cycle         = 0;
        sentCount     = 0;
        holdCount     = 0;
        errors        = 0;
        flowErrors    = 0;
        expectTotal   = 0;
        lastDogX      = 10'd0;
        runValue      = 1'b0;
        holdMask      = 16'd0;
        loadTestData();
        repeat (8) @(posedge ANIM_Clk);
        #1 Reset = 1'b0;
        repeat (30) @(posedge ANIM_Clk);
        if (sentCount != 0)
        begin
            flowErrors++;
            $display("Commands appeared while run was low");
        end
        #1 run = runValue;
        while (sentCount == 0)
            @(posedge ANIM_Clk);
        #1 run = 1'b0;          // One pass of the sequence only
        while (dogQ.size() != 0 || duckQ.size() != 0)
            @(posedge ANIM_Clk);
        repeat (300) @(posedge ANIM_Clk);
        if (holdCount == 0)
        begin
            flowErrors++;
            $display("No dog hold frames seen during the duck flight");
        end
        if (sentCount != expectTotal + holdCount)
        begin
            flowErrors++;
            $display("Command count %0d does not match %0d expected plus %0d hold",
                     sentCount, expectTotal, holdCount);
        end
        $display("Errors: %0d value, %0d flow; commands %0d, hold frames %0d",
                 errors, flowErrors, sentCount, holdCount);
        if (errors == 0 && flowErrors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // Watchdog sized from the expected stream
    initial
    begin
        #1;
        repeat ((expectTotal + 1) * 40 + MARGIN_CYCLES) @(posedge ANIM_Clk);
        $display("Timeout: the command stream did not finish in time");
        $display("test failed");
        $finish;
    end

endmodule

// ==== sim/duckAnim_assert.sv ====
`timescale 1ns/100ps

module duckAnim_assert #(
    parameter int CMD_CREDITS = 4,
    parameter int CREDIT_W    = $clog2(CMD_CREDITS + 1)
) (
    input logic                ANIM_Clk,
    input logic                Reset,
    input logic                cmdValid,
    input logic                cmdCredit,
    input logic [CREDIT_W-1:0] creditCount,
    input logic                dogGrant,
    input logic                duckGrant
);

    int inFlight;     // Commands held by the renderer

    always_ff @(posedge ANIM_Clk or posedge Reset)
    begin
        if (Reset)
            inFlight <= 0;
        else
            inFlight <= inFlight + int'(cmdValid) - int'(cmdCredit);
    end

    // A command leaves only when a renderer slot was free
    creditUsed: assert property (@(posedge ANIM_Clk) disable iff (Reset)
        cmdValid |-> inFlight < CMD_CREDITS)
        else $error("cmdValid issued with no credit left");

    creditLimit: assert property (@(posedge ANIM_Clk) disable iff (Reset)
        creditCount <= CREDIT_W'(CMD_CREDITS))
        else $error("Credit count above the renderer depth");

    oneGrant: assert property (@(posedge ANIM_Clk) disable iff (Reset)
        !(dogGrant && duckGrant))
        else $error("ROM granted to both ports at once");   // Single ROM read port

endmodule

bind duckAnimTop duckAnim_assert #(.CMD_CREDITS(CMD_CREDITS)) uAssert (
    .ANIM_Clk    (ANIM_Clk),
    .Reset       (Reset),
    .cmdValid    (cmdValid),
    .cmdCredit   (cmdCredit),
    .creditCount (uCmdOut.creditCount),
    .dogGrant    (dogRom.grant),
    .duckGrant   (duckRom.grant)
);

// ==== src/duckAnimTop.sv ====
`timescale 1ns/100ps

module duckAnimTop import animPkg::*; #(
    parameter int WALK_SEGMENTS = 2,
    parameter int WAIT_FRAMES   = 10,
    parameter int FLIGHT_STEPS  = 12,
    parameter int CMD_CREDITS   = 4
) (
    input  logic       ANIM_Clk,
    input  logic       Reset,
    input  logic       frameTick,
    input  logic       run,
    input  logic [1:0] duckColor,
    input  logic [1:0] duckDirection,
    input  logic [9:0] duckStartX,
    input  logic       cmdCredit,
    output logic       cmdValid,
    output logic       cmdSprite,
    output logic [4:0] cmdFrame,
    output logic [9:0] cmdX,
    output logic [9:0] cmdY
);

    spriteCmd_t dogCmd;
    spriteCmd_t duckCmd;
    logic       dogPending;
    logic       duckPending;
    logic       dogAccept;
    logic       duckAccept;
    logic       duckLaunch;    // Dog hands over to the duck
    logic       duckDone;

    pathRomBus dogRom ();
    pathRomBus duckRom ();

    pathRomArbiter uArbiter (
        .ANIM_Clk (ANIM_Clk),
        .Reset    (Reset),
        .dogPort  (dogRom),
        .duckPort (duckRom)
    );

    dogControl #(
        .WALK_SEGMENTS (WALK_SEGMENTS),
        .WAIT_FRAMES   (WAIT_FRAMES)
    ) uDog (
        .ANIM_Clk   (ANIM_Clk),
        .Reset      (Reset),
        .frameTick  (frameTick),
        .run        (run),
        .rom        (dogRom),
        .dogCmd     (dogCmd),
        .dogPending (dogPending),
        .dogAccept  (dogAccept),
        .duckLaunch (duckLaunch),
        .duckDone   (duckDone)
    );

    duckControl #(
        .FLIGHT_STEPS (FLIGHT_STEPS)
    ) uDuck (
        .ANIM_Clk      (ANIM_Clk),
        .Reset         (Reset),
        .frameTick     (frameTick),
        .duckLaunch    (duckLaunch),
        .duckColor     (duckColor),
        .duckDirection (duckDirection),
        .duckStartX    (duckStartX),
        .rom           (duckRom),
        .duckCmd       (duckCmd),
        .duckPending   (duckPending),
        .duckAccept    (duckAccept),
        .duckDone      (duckDone)
    );

    spriteCmdOut #(
        .CMD_CREDITS (CMD_CREDITS)
    ) uCmdOut (
        .ANIM_Clk    (ANIM_Clk),
        .Reset       (Reset),
        .dogCmd      (dogCmd),
        .dogPending  (dogPending),
        .duckCmd     (duckCmd),
        .duckPending (duckPending),
        .dogAccept   (dogAccept),
        .duckAccept  (duckAccept),
        .cmdCredit   (cmdCredit),
        .cmdValid    (cmdValid),
        .cmdSprite   (cmdSprite),
        .cmdFrame    (cmdFrame),
        .cmdX        (cmdX),
        .cmdY        (cmdY)
    );

endmodule

// ==== src/spriteCmdOut.sv ====
`timescale 1ns/100ps

module spriteCmdOut import animPkg::*; #(
    parameter int CMD_CREDITS = 4
) (
    input  logic       ANIM_Clk,
    input  logic       Reset,
    input  spriteCmd_t dogCmd,
    input  logic       dogPending,
    input  spriteCmd_t duckCmd,
    input  logic       duckPending,
    output logic       dogAccept,
    output logic       duckAccept,
    input  logic       cmdCredit,
    output logic       cmdValid,
    output logic       cmdSprite,
    output logic [4:0] cmdFrame,
    output logic [9:0] cmdX,
    output logic [9:0] cmdY
);

    localparam int CREDIT_W = $clog2(CMD_CREDITS + 1);

    logic [CREDIT_W-1:0] creditCount;    // Free slots in the renderer
    logic                haveCredit;
    logic                send;
    spriteCmd_t          chosen;

    // Dog wins a tie, duck follows next cycle
    assign haveCredit = (creditCount != '0);
    assign dogAccept  = haveCredit && dogPending;
    assign duckAccept = haveCredit && duckPending && !dogPending;
    assign send       = dogAccept || duckAccept;
    assign chosen     = dogPending ? dogCmd : duckCmd;

    always_ff @(posedge ANIM_Clk or posedge Reset)
    begin
        if (Reset)
        begin
            creditCount <= CREDIT_W'(CMD_CREDITS);
            cmdValid    <= 1'b0;
        end
        else
        begin
            cmdValid <= send;
            case ({send, cmdCredit})
                2'b10:   creditCount <= creditCount - CREDIT_W'(1);
                2'b01:   creditCount <= creditCount + CREDIT_W'(1);
                default: ;     // Both or neither leave the count alone
            endcase
        end
    end

    always_ff @(posedge ANIM_Clk)
    begin
        if (send)
        begin
            cmdSprite <= chosen.sprite;
            cmdFrame  <= chosen.frame;
            cmdX      <= chosen.x;
            cmdY      <= chosen.y;
        end
    end

endmodule

// ==== src/duckControl.sv ====
`timescale 1ns/100ps

module duckControl import animPkg::*; #(
    parameter int FLIGHT_STEPS = 12
) (
    input  logic         ANIM_Clk,
    input  logic         Reset,
    input  logic         frameTick,
    input  logic         duckLaunch,
    input  logic [1:0]   duckColor,
    input  logic [1:0]   duckDirection,
    input  logic [9:0]   duckStartX,
    pathRomBus.requester rom,
    output spriteCmd_t   duckCmd,
    output logic         duckPending,
    input  logic         duckAccept,
    output logic         duckDone
);

    localparam int STEP_W = $clog2(FLIGHT_STEPS + 1);
    localparam logic [9:0] DUCK_SPEED = 10'd4;

    duckState_e        state;
    logic [1:0]        color;
    logic [1:0]        direction;    // 00 NW, 01 W, 10 NE, 11 E
    logic [9:0]        startX;
    logic [STEP_W-1:0] stepCnt;
    logic [1:0]        flapIdx;
    logic              romWait;
    logic              step;
    logic              cmdLoad;
    logic [4:0]        baseFrame;
    spriteCmd_t        cmdNext;

    assign step      = frameTick && !duckPending && !rom.req && !romWait;
    assign cmdLoad   = romWait || (step && state == Start);
    assign baseFrame = {color, direction, 1'b0};     // Colour*8 + direction*2

    // Flight moves from the previous command position
    always_comb
    begin
        cmdNext.sprite = SprDuck;
        if (state == Start)
        begin
            cmdNext.frame = baseFrame;
            cmdNext.x     = startX;
            cmdNext.y     = DUCK_START_Y;
        end
        else
        begin
            cmdNext.frame = baseFrame + rom.data[4:0];
            cmdNext.x     = direction[1] ? duckCmd.x + DUCK_SPEED : duckCmd.x - DUCK_SPEED;
            cmdNext.y     = duckCmd.y - DUCK_SPEED;
        end
    end

    always_ff @(posedge ANIM_Clk)
    begin
        if (state == Parked && duckLaunch)
        begin
            color     <= duckColor;
            direction <= duckDirection;
            startX    <= duckStartX;
        end
        if (cmdLoad)
            duckCmd <= cmdNext;
    end

    always_ff @(posedge ANIM_Clk or posedge Reset)
    begin
        if (Reset)
        begin
            state       <= Parked;
            stepCnt     <= '0;
            flapIdx     <= 2'd0;
            romWait     <= 1'b0;
            rom.req     <= 1'b0;
            rom.addr    <= '0;
            duckPending <= 1'b0;
            duckDone    <= 1'b0;
        end
        else
        begin
            duckDone <= 1'b0;
            romWait  <= rom.grant;
            if (rom.grant)
                rom.req <= 1'b0;
            if (cmdLoad)
                duckPending <= 1'b1;
            else if (duckAccept)
                duckPending <= 1'b0;

            case (state)
                Parked:
                    if (duckLaunch)
                        state <= Start;
                Start:
                    if (step)
                    begin
                        state   <= Fly;
                        stepCnt <= '0;
                        flapIdx <= 2'd0;
                    end
                Fly:
                begin
                    if (step)
                    begin
                        rom.req  <= 1'b1;
                        rom.addr <= FLAP_BASE + ROM_ADDR_W'(flapIdx);
                    end
                    if (romWait)
                    begin
                        flapIdx <= flapIdx + 2'd1;
                        stepCnt <= stepCnt + STEP_W'(1);
                        if (stepCnt == STEP_W'(FLIGHT_STEPS - 1))
                        begin
                            state    <= Gone;
                            duckDone <= 1'b1;
                        end
                    end
                end
                Gone: state <= Parked;     // Ready for the next launch
                default: state <= Parked;
            endcase
        end
    end

endmodule

// ==== src/dogControl.sv ====
`timescale 1ns/100ps

module dogControl import animPkg::*; #(
    parameter int WALK_SEGMENTS = 2,
    parameter int WAIT_FRAMES   = 10
) (
    input  logic         ANIM_Clk,
    input  logic         Reset,
    input  logic         frameTick,
    input  logic         run,
    pathRomBus.requester rom,
    output spriteCmd_t   dogCmd,
    output logic         dogPending,
    input  logic         dogAccept,
    output logic         duckLaunch,
    input  logic         duckDone
);

    localparam int SEG_W  = $clog2(WALK_SEGMENTS + 1);
    localparam int WAIT_W = $clog2(WAIT_FRAMES + 1);

    dogState_e         state;        // Frame shown on the next tick
    logic [9:0]        baseX;        // X at the end of the last walk cycle
    logic [SEG_W-1:0]  segCnt;
    logic              secondSniff;
    logic [3:0]        arcIdx;
    logic [WAIT_W-1:0] waitCnt;
    logic [1:0]        bobIdx;
    logic              duckGone;     // Duck finished, leave Hold
    logic              romWait;
    logic              step;
    logic              tickEmit;
    logic              cmdLoad;
    logic [9:0]        walkX;
    spriteCmd_t        cmdNext;

    // Tick only counts when nothing is in flight
    assign step     = frameTick && !dogPending && !rom.req && !romWait;
    assign tickEmit = (state == Idle) ? run
                    : (state inside {Walk1, Walk2, Walk3, Walk4, Sniff1, Sniff2, Surprised});
    assign cmdLoad  = romWait || (step && tickEmit);
    assign walkX    = baseX + WALK_STRIDE * 10'(state - Walk1 + 1);

    always_comb
    begin
        cmdNext.sprite = SprDog;
        cmdNext.frame  = 5'd0;
        cmdNext.x      = baseX;
        cmdNext.y      = DOG_GROUND_Y;
        case (state)
            Idle:
                cmdNext.x = DOG_START_X;
            Walk1:
            begin
                cmdNext.frame = 5'd1;
                cmdNext.x     = walkX;
            end
            Walk2:
            begin
                cmdNext.frame = 5'd2;
                cmdNext.x     = walkX;
            end
            Walk3, Walk4:
            begin
                cmdNext.frame = 5'd3;
                cmdNext.x     = walkX;
            end
            Sniff1:    cmdNext.frame = 5'd4;
            Sniff2:    cmdNext.frame = 5'd5;
            Surprised: cmdNext.frame = 5'd6;
            Jump, Fall:
            begin
                cmdNext.frame = (state == Jump) ? 5'd7 : 5'd8;
                cmdNext.x     = baseX + rom.data[19:10];
                cmdNext.y     = rom.data[9:0];
            end
            Hold:
            begin
                cmdNext.frame = 5'd9;
                cmdNext.x     = dogCmd.x;                 // Last fall point
                cmdNext.y     = DOG_GROUND_Y - rom.data[9:0];
            end
            default: ;
        endcase
    end

    always_ff @(posedge ANIM_Clk)
    begin
        if (cmdLoad)
            dogCmd <= cmdNext;
    end

    always_ff @(posedge ANIM_Clk or posedge Reset)
    begin
        if (Reset)
        begin
            state       <= Idle;
            baseX       <= DOG_START_X;
            segCnt      <= '0;
            secondSniff <= 1'b0;
            arcIdx      <= 4'd0;
            waitCnt     <= '0;
            bobIdx      <= 2'd0;
            duckGone    <= 1'b0;
            romWait     <= 1'b0;
            rom.req     <= 1'b0;
            rom.addr    <= '0;
            dogPending  <= 1'b0;
            duckLaunch  <= 1'b0;
        end
        else
        begin
            duckLaunch <= 1'b0;
            romWait    <= rom.grant;
            if (rom.grant)
                rom.req <= 1'b0;
            if (cmdLoad)
                dogPending <= 1'b1;
            else if (dogAccept)
                dogPending <= 1'b0;

            // ROM word in hand, step the table index
            if (romWait)
            begin
                if (state == Hold)
                    bobIdx <= bobIdx + 2'd1;
                else if (arcIdx == 4'd9)
                begin
                    arcIdx <= 4'd0;
                    state  <= (state == Jump) ? Fall : Wait;
                end
                else
                    arcIdx <= arcIdx + 4'd1;
            end

            if (step)
            begin
                case (state)
                    Idle:
                        if (run)
                        begin
                            state       <= Walk1;
                            baseX       <= DOG_START_X;
                            segCnt      <= '0;
                            secondSniff <= 1'b0;
                        end
                    Walk1: state <= Walk2;
                    Walk2: state <= Walk3;
                    Walk3: state <= Walk4;
                    Walk4:
                    begin
                        baseX <= baseX + SEGMENT_STRIDE;
                        if (segCnt == SEG_W'(WALK_SEGMENTS - 1))
                        begin
                            segCnt <= '0;
                            state  <= Sniff1;
                        end
                        else
                        begin
                            segCnt <= segCnt + SEG_W'(1);
                            state  <= Walk1;
                        end
                    end
                    Sniff1: state <= Sniff2;
                    Sniff2:
                    begin
                        secondSniff <= 1'b1;
                        state       <= secondSniff ? Surprised : Walk1;
                    end
                    Surprised: state <= Jump;
                    Jump, Fall:
                    begin
                        rom.req  <= 1'b1;
                        rom.addr <= ((state == Jump) ? JUMP_BASE : FALL_BASE)
                                  + ROM_ADDR_W'(arcIdx);
                    end
                    Wait:
                        if (waitCnt == WAIT_W'(WAIT_FRAMES - 1))
                        begin
                            waitCnt <= '0;
                            state   <= Launch;
                        end
                        else
                            waitCnt <= waitCnt + WAIT_W'(1);
                    Launch:
                    begin
                        duckLaunch <= 1'b1;
                        duckGone   <= 1'b0;
                        state      <= Hold;
                    end
                    Hold:
                        if (duckGone)
                        begin
                            duckGone <= 1'b0;
                            state    <= Idle;
                        end
                        else
                        begin
                            rom.req  <= 1'b1;
                            rom.addr <= BOB_BASE + ROM_ADDR_W'(bobIdx);
                        end
                    default: state <= Idle;
                endcase
            end

            if (duckDone)
                duckGone <= 1'b1;
        end
    end

endmodule

// ==== src/pathRomArbiter.sv ====
`timescale 1ns/100ps

module pathRomArbiter import animPkg::*; (
    input  logic       ANIM_Clk,
    input  logic       Reset,
    pathRomBus.arbiter dogPort,
    pathRomBus.arbiter duckPort
);

    localparam int IDX_W = $clog2(ROM_DEPTH);

    logic duckFirst;     // Priority flips after every grant
    logic dogWant;
    logic duckWant;
    logic dogWin;
    logic duckWin;

    // A port already holding grant is not served again
    assign dogWant  = dogPort.req && !dogPort.grant;
    assign duckWant = duckPort.req && !duckPort.grant;
    assign dogWin   = dogWant && (!duckWant || !duckFirst);
    assign duckWin  = duckWant && !dogWin;

    always_ff @(posedge ANIM_Clk or posedge Reset)
    begin
        if (Reset)
        begin
            dogPort.grant  <= 1'b0;
            duckPort.grant <= 1'b0;
            duckFirst      <= 1'b0;
        end
        else
        begin
            dogPort.grant  <= dogWin;
            duckPort.grant <= duckWin;
            if (dogWin || duckWin)
                duckFirst <= dogWin;
        end
    end

    // Address is still held while grant is high
    always_ff @(posedge ANIM_Clk)
    begin
        if (dogPort.grant)
            dogPort.data <= PATH_ROM[dogPort.addr[IDX_W-1:0]];
        if (duckPort.grant)
            duckPort.data <= PATH_ROM[duckPort.addr[IDX_W-1:0]];
    end

endmodule

// ==== src/pathRomBus.sv ====
`timescale 1ns/100ps

// One ROM read channel, req and addr held until grant
interface pathRomBus import animPkg::*; ();

    logic                  req;
    logic [ROM_ADDR_W-1:0] addr;
    logic                  grant;     // One cycle wide
    logic [ROM_W-1:0]      data;      // Valid the cycle after grant only

    modport requester (
        output req,
        output addr,
        input  grant,
        input  data
    );

    modport arbiter (
        input  req,
        input  addr,
        output grant,
        output data
    );

endinterface

// ==== src/animPkg.sv ====
package animPkg;

    typedef enum logic [3:0] {
        Idle, Walk1, Walk2, Walk3, Walk4, Sniff1, Sniff2, Surprised,
        Jump, Fall, Wait, Launch, Hold
    } dogState_e;

    typedef enum logic [1:0] {Parked, Start, Fly, Gone} duckState_e;

    typedef enum logic {SprDog, SprDuck} sprite_e;

    typedef struct packed {
        sprite_e    sprite;
        logic [4:0] frame;
        logic [9:0] x;
        logic [9:0] y;
    } spriteCmd_t;

    localparam logic [9:0] DOG_GROUND_Y   = 10'd290;
    localparam logic [9:0] DOG_START_X    = 10'd11;
    localparam logic [9:0] WALK_STRIDE    = 10'd8;      // Pixels per walk frame
    localparam logic [9:0] SEGMENT_STRIDE = 10'd32;     // Pixels per walk cycle
    localparam logic [9:0] DUCK_START_Y   = 10'd300;

    localparam int ROM_ADDR_W = 6;
    localparam int ROM_W      = 20;
    localparam int ROM_DEPTH  = 28;

    localparam logic [ROM_ADDR_W-1:0] JUMP_BASE = 6'd0;
    localparam logic [ROM_ADDR_W-1:0] FALL_BASE = 6'd10;
    localparam logic [ROM_ADDR_W-1:0] FLAP_BASE = 6'd20;
    localparam logic [ROM_ADDR_W-1:0] BOB_BASE  = 6'd24;

    // Arc words are {X offset from jump start, absolute Y}
    localparam logic [ROM_W-1:0] PATH_ROM [ROM_DEPTH] = '{
        {10'd0, 10'd290},   {10'd9, 10'd274},   {10'd18, 10'd260},  {10'd27, 10'd248},
        {10'd36, 10'd238},  {10'd45, 10'd229},  {10'd54, 10'd222},  {10'd63, 10'd217},
        {10'd74, 10'd213},  {10'd85, 10'd212},
        {10'd85, 10'd212},  {10'd96, 10'd213},  {10'd107, 10'd217}, {10'd116, 10'd222},
        {10'd125, 10'd229}, {10'd134, 10'd238}, {10'd143, 10'd248}, {10'd152, 10'd260},
        {10'd161, 10'd274}, {10'd170, 10'd290},
        {10'd0, 10'd0},     {10'd0, 10'd1},     {10'd0, 10'd1},     {10'd0, 10'd0},  // Flap
        {10'd0, 10'd0},     {10'd0, 10'd2},     {10'd0, 10'd4},     {10'd0, 10'd2}   // Bob
    };

endpackage
